// ==== common/conv_macros.svh ====
// Convolution engine constants
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

`define CONV_DWIDTH      32
`define CONV_WT_DIM      3
`define CONV_MAX_DIM     16
// must stay above CONV_WT_DIM so every PE is granted before the next pixel
`define CONV_PIX_GAP     4
`define CONV_FIFO_DEPTH  8

// padded coordinate, runs 0 to fm_dim + 1
`define CONV_CRD_W       $clog2(`CONV_MAX_DIM + 2)
// output column inside the partial-sum buffer
`define CONV_COL_W       $clog2(`CONV_MAX_DIM)
// kernel row, kernel column and buffer slot
`define CONV_IDX_W       $clog2(`CONV_WT_DIM)
`define CONV_GAP_W       $clog2(`CONV_PIX_GAP)

`endif

// ==== common/conv_pkg.sv ====
// Convolution engine types
`default_nettype none

package conv_pkg;

    // halo sequencer phase
    typedef enum logic {
        SEQ_LOAD,
        SEQ_STREAM
    } seq_state_t;

    // partial-sum buffer operation carried with every PE request
    typedef enum logic [1:0] {
        PSUM_INIT,
        PSUM_ADD,
        PSUM_FINAL
    } psum_op_t;

endpackage

`default_nettype wire

// ==== source/halo_sequencer.sv ====
// Halo sequencer
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module halo_sequencer import conv_pkg::*; (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic [`CONV_CRD_W-1:0]    fm_dim_i,
    input  wire logic [`CONV_DWIDTH-1:0]   weight_i,
    input  wire logic                      weight_valid_i,
    input  wire logic [`CONV_DWIDTH-1:0]   fm_data_i,
    input  wire logic                      fm_valid_i,
    output logic      [`CONV_WT_DIM-1:0]   wt_load_o,
    output logic      [`CONV_IDX_W-1:0]    wt_col_o,
    output logic      [`CONV_DWIDTH-1:0]   wt_data_o,
    output logic                           pix_valid_o,
    output logic      [`CONV_DWIDTH-1:0]   pix_data_o,
    output logic      [`CONV_CRD_W-1:0]    pix_row_o,
    output logic      [`CONV_CRD_W-1:0]    pix_col_o,
    output logic                           busy_o
);

    localparam int DW    = `CONV_DWIDTH;
    localparam int N     = `CONV_WT_DIM;
    localparam int CRD_W = `CONV_CRD_W;
    localparam int IDX_W = `CONV_IDX_W;
    localparam int GAP_W = `CONV_GAP_W;
    localparam int DEPTH = `CONV_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    seq_state_t       state_q;
    logic [IDX_W-1:0] wt_row_q;
    logic [IDX_W-1:0] wt_col_q;
    logic             busy_q;
    logic             wt_fire;
    logic             wt_last;

    logic [DW-1:0]    fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] fifo_cnt_q;
    logic             fifo_full;
    logic             fifo_empty;
    logic             push;
    logic             pop;

    logic [GAP_W-1:0] gap_q;
    logic [CRD_W-1:0] row_q;
    logic [CRD_W-1:0] col_q;
    logic [CRD_W-1:0] dim_last;
    logic             halo;
    logic             issue;
    logic             frame_end;

    // weights arrive row-major, m/n style counters pick PE and tap
    assign wt_fire = (state_q == SEQ_LOAD) && weight_valid_i;
    assign wt_last = wt_fire && (wt_row_q == IDX_W'(N - 1)) && (wt_col_q == IDX_W'(N - 1));

    always_comb begin
        wt_load_o = '0;
        if (wt_fire) begin
            wt_load_o[wt_row_q] = 1'b1;
        end
    end

    assign wt_col_o  = wt_col_q;
    assign wt_data_o = weight_i;
    assign busy_o    = busy_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= SEQ_LOAD;
            wt_row_q <= '0;
            wt_col_q <= '0;
            busy_q   <= 1'b0;
        end else begin
            if (wt_fire) begin
                busy_q <= 1'b1;
                if (wt_col_q == IDX_W'(N - 1)) begin
                    wt_col_q <= '0;
                    wt_row_q <= (wt_row_q == IDX_W'(N - 1)) ? '0 : wt_row_q + 1'b1;
                end else begin
                    wt_col_q <= wt_col_q + 1'b1;
                end
            end
            if (wt_last) begin
                state_q <= SEQ_STREAM;
            end else if (frame_end) begin
                state_q <= SEQ_LOAD;
                busy_q  <= 1'b0;
            end
        end
    end

    // input FIFO soaks up real pixels while halo slots are issued
    assign fifo_full  = (fifo_cnt_q == CNT_W'(DEPTH));
    assign fifo_empty = (fifo_cnt_q == '0);
    assign push       = fm_valid_i && !fifo_full;
    assign pop        = issue && !halo;

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= fm_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            fifo_cnt_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                fifo_cnt_q <= fifo_cnt_q + 1'b1;
            end else if (pop && !push) begin
                fifo_cnt_q <= fifo_cnt_q - 1'b1;
            end
        end
    end

    // padded raster walk, one position per gap
    assign dim_last  = fm_dim_i + 1'b1;
    assign halo      = (row_q == '0) || (col_q == '0) || (row_q == dim_last) || (col_q == dim_last);
    assign issue     = (state_q == SEQ_STREAM) && (gap_q == '0) && (halo || !fifo_empty);
    assign frame_end = issue && (row_q == dim_last) && (col_q == dim_last);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gap_q       <= '0;
            row_q       <= '0;
            col_q       <= '0;
            pix_valid_o <= 1'b0;
        end else begin
            pix_valid_o <= issue;
            if (issue) begin
                gap_q <= GAP_W'(`CONV_PIX_GAP - 1);
                if (col_q == dim_last) begin
                    col_q <= '0;
                    row_q <= (row_q == dim_last) ? '0 : row_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end else if (gap_q != '0) begin
                gap_q <= gap_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            pix_data_o <= halo ? '0 : fifo_mem[rd_ptr_q];
            pix_row_o  <= row_q;
            pix_col_o  <= col_q;
        end
    end

endmodule

`default_nettype wire

// ==== source/conv_row_pe.sv ====
// Kernel row processing element
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_row_pe import conv_pkg::*; #(
    parameter int ROW_INDEX = 0
) (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic [`CONV_CRD_W-1:0]    fm_dim_i,
    input  wire logic                      wt_load_i,
    input  wire logic [`CONV_IDX_W-1:0]    wt_col_i,
    input  wire logic [`CONV_DWIDTH-1:0]   wt_data_i,
    input  wire logic                      pix_valid_i,
    input  wire logic [`CONV_DWIDTH-1:0]   pix_data_i,
    input  wire logic [`CONV_CRD_W-1:0]    pix_row_i,
    input  wire logic [`CONV_CRD_W-1:0]    pix_col_i,
    input  wire logic                      gnt_i,
    output logic                           req_o,
    output logic      [`CONV_DWIDTH-1:0]   req_data_o,
    output psum_op_t                       req_op_o,
    output logic      [`CONV_IDX_W-1:0]    req_slot_o,
    output logic      [`CONV_COL_W-1:0]    req_col_o
);

    localparam int DW    = `CONV_DWIDTH;
    localparam int N     = `CONV_WT_DIM;
    localparam int CRD_W = `CONV_CRD_W;
    localparam int IDX_W = `CONV_IDX_W;
    localparam int COL_W = `CONV_COL_W;

    // last row finishes the pixel, first row opens it, the rest accumulate
    localparam psum_op_t ROW_OP = (ROW_INDEX == N - 1) ? PSUM_FINAL :
                                  (ROW_INDEX == 0)     ? PSUM_INIT  : PSUM_ADD;

    logic [DW-1:0]    wt_q  [N];
    logic [DW-1:0]    win_q [N];
    logic [CRD_W-1:0] row_off;
    logic [CRD_W-1:0] col_off;
    logic             hit;
    logic             req_q;
    logic [IDX_W-1:0] slot_q;
    logic [COL_W-1:0] col_q;
    logic [DW-1:0]    dot;

    always_ff @(posedge clk_i) begin
        if (wt_load_i) begin
            wt_q[wt_col_i] <= wt_data_i;
        end
    end

    // win_q[N-1] is the newest pixel, restart at the left halo column
    always_ff @(posedge clk_i) begin
        if (pix_valid_i) begin
            for (int k = 0; k < N - 1; k++) begin
                win_q[k] <= (pix_col_i == '0) ? '0 : win_q[k + 1];
            end
            win_q[N - 1] <= pix_data_i;
        end
    end

    // output pixel (row_off, col_off) once the window spans a full kernel row
    assign row_off = pix_row_i - CRD_W'(ROW_INDEX);
    assign col_off = pix_col_i - CRD_W'(N - 1);
    assign hit     = pix_valid_i
                  && (pix_row_i >= CRD_W'(ROW_INDEX))
                  && (row_off < fm_dim_i)
                  && (pix_col_i >= CRD_W'(N - 1));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q <= 1'b0;
        end else if (hit) begin
            req_q <= 1'b1;
        end else if (gnt_i) begin
            req_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (hit) begin
            slot_q <= IDX_W'(row_off % N);
            col_q  <= col_off[COL_W-1:0];
        end
    end

    // window is frozen while the request waits, so the sum stays put
    always_comb begin
        dot = '0;
        for (int k = 0; k < N; k++) begin
            dot = dot + wt_q[k] * win_q[k];
        end
    end

    assign req_o      = req_q;
    assign req_data_o = dot;
    assign req_op_o   = ROW_OP;
    assign req_slot_o = slot_q;
    assign req_col_o  = col_q;

endmodule

`default_nettype wire

// ==== psum/psum_arbiter.sv ====
// Partial-sum round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module psum_arbiter import conv_pkg::*; (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic [`CONV_WT_DIM-1:0]   req_i,
    input  wire logic [`CONV_DWIDTH-1:0]   req_data_i [`CONV_WT_DIM],
    input  wire psum_op_t                  req_op_i   [`CONV_WT_DIM],
    input  wire logic [`CONV_IDX_W-1:0]    req_slot_i [`CONV_WT_DIM],
    input  wire logic [`CONV_COL_W-1:0]    req_col_i  [`CONV_WT_DIM],
    output logic      [`CONV_WT_DIM-1:0]   gnt_o,
    output logic                           wr_valid_o,
    output logic      [`CONV_DWIDTH-1:0]   wr_data_o,
    output psum_op_t                       wr_op_o,
    output logic      [`CONV_IDX_W-1:0]    wr_slot_o,
    output logic      [`CONV_COL_W-1:0]    wr_col_o
);

    localparam int N     = `CONV_WT_DIM;
    localparam int IDX_W = `CONV_IDX_W;

    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] sel;
    logic             found;

    // search starts just after the PE granted last
    always_comb begin
        int idx;
        sel   = '0;
        found = 1'b0;
        for (int k = 1; k <= N; k++) begin
            idx = (int'(last_q) + k) % N;
            if (!found && req_i[idx]) begin
                found = 1'b1;
                sel   = IDX_W'(idx);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_q <= IDX_W'(N - 1);
        end else if (found) begin
            last_q <= sel;
        end
    end

    assign gnt_o      = found ? (N'(1) << sel) : '0;
    assign wr_valid_o = found;
    assign wr_data_o  = req_data_i[sel];
    assign wr_op_o    = req_op_i[sel];
    assign wr_slot_o  = req_slot_i[sel];
    assign wr_col_o   = req_col_i[sel];

endmodule

`default_nettype wire

// ==== psum/psum_buffer.sv ====
// Partial-sum ring buffer
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module psum_buffer import conv_pkg::*; (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic                      wr_valid_i,
    input  wire logic [`CONV_DWIDTH-1:0]   wr_data_i,
    input  wire psum_op_t                  wr_op_i,
    input  wire logic [`CONV_IDX_W-1:0]    wr_slot_i,
    input  wire logic [`CONV_COL_W-1:0]    wr_col_i,
    output logic      [`CONV_DWIDTH-1:0]   out_data_o,
    output logic                           out_valid_o
);

    localparam int DW   = `CONV_DWIDTH;
    localparam int N    = `CONV_WT_DIM;
    localparam int COLS = `CONV_MAX_DIM;

    // one slot per output row in flight, indexed by row modulo kernel size
    logic [DW-1:0] mem [N][COLS];
    logic [DW-1:0] entry;
    logic [DW-1:0] sum;
    logic          final_wr;

    assign entry    = mem[wr_slot_i][wr_col_i];
    assign sum      = entry + wr_data_i;
    assign final_wr = wr_valid_i && (wr_op_i == PSUM_FINAL);

    always_ff @(posedge clk_i) begin
        if (wr_valid_i) begin
            case (wr_op_i)
                PSUM_INIT: begin
                    mem[wr_slot_i][wr_col_i] <= wr_data_i;
                end
                PSUM_ADD: begin
                    mem[wr_slot_i][wr_col_i] <= sum;
                end
                default: begin
                    // entry is free again for the row three rows down
                    mem[wr_slot_i][wr_col_i] <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (final_wr) begin
            out_data_o <= sum;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= final_wr;
        end
    end

endmodule

`default_nettype wire

// ==== source/conv2d_top.sv ====
// 2D convolution engine top
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv2d_top import conv_pkg::*; (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic [`CONV_CRD_W-1:0]    fm_dim_i,
    input  wire logic [`CONV_DWIDTH-1:0]   weight_i,
    input  wire logic                      weight_valid_i,
    input  wire logic [`CONV_DWIDTH-1:0]   fm_data_i,
    input  wire logic                      fm_valid_i,
    output logic      [`CONV_DWIDTH-1:0]   out_data_o,
    output logic                           out_valid_o,
    output logic                           busy_o
);

    localparam int DW    = `CONV_DWIDTH;
    localparam int N     = `CONV_WT_DIM;
    localparam int CRD_W = `CONV_CRD_W;
    localparam int IDX_W = `CONV_IDX_W;
    localparam int COL_W = `CONV_COL_W;

    logic [N-1:0]     wt_load;
    logic [IDX_W-1:0] wt_col;
    logic [DW-1:0]    wt_data;
    logic             pix_valid;
    logic [DW-1:0]    pix_data;
    logic [CRD_W-1:0] pix_row;
    logic [CRD_W-1:0] pix_col;

    logic [N-1:0]     req;
    logic [N-1:0]     gnt;
    logic [DW-1:0]    req_data [N];
    psum_op_t         req_op   [N];
    logic [IDX_W-1:0] req_slot [N];
    logic [COL_W-1:0] req_col  [N];

    logic             wr_valid;
    logic [DW-1:0]    wr_data;
    psum_op_t         wr_op;
    logic [IDX_W-1:0] wr_slot;
    logic [COL_W-1:0] wr_col;

    halo_sequencer u_seq (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fm_dim_i       (fm_dim_i),
        .weight_i       (weight_i),
        .weight_valid_i (weight_valid_i),
        .fm_data_i      (fm_data_i),
        .fm_valid_i     (fm_valid_i),
        .wt_load_o      (wt_load),
        .wt_col_o       (wt_col),
        .wt_data_o      (wt_data),
        .pix_valid_o    (pix_valid),
        .pix_data_o     (pix_data),
        .pix_row_o      (pix_row),
        .pix_col_o      (pix_col),
        .busy_o         (busy_o)
    );

    // one PE per kernel row
    for (genvar g = 0; g < N; g++) begin : g_pe
        conv_row_pe #(
            .ROW_INDEX (g)
        ) u_pe (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .fm_dim_i    (fm_dim_i),
            .wt_load_i   (wt_load[g]),
            .wt_col_i    (wt_col),
            .wt_data_i   (wt_data),
            .pix_valid_i (pix_valid),
            .pix_data_i  (pix_data),
            .pix_row_i   (pix_row),
            .pix_col_i   (pix_col),
            .gnt_i       (gnt[g]),
            .req_o       (req[g]),
            .req_data_o  (req_data[g]),
            .req_op_o    (req_op[g]),
            .req_slot_o  (req_slot[g]),
            .req_col_o   (req_col[g])
        );
    end

    psum_arbiter u_arb (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req),
        .req_data_i (req_data),
        .req_op_i   (req_op),
        .req_slot_i (req_slot),
        .req_col_i  (req_col),
        .gnt_o      (gnt),
        .wr_valid_o (wr_valid),
        .wr_data_o  (wr_data),
        .wr_op_o    (wr_op),
        .wr_slot_o  (wr_slot),
        .wr_col_o   (wr_col)
    );

    psum_buffer u_buf (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wr_valid_i  (wr_valid),
        .wr_data_i   (wr_data),
        .wr_op_i     (wr_op),
        .wr_slot_i   (wr_slot),
        .wr_col_i    (wr_col),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o)
    );

endmodule

`default_nettype wire

// ==== tests/conv2d_checker.sv ====
// Convolution engine protocol checker
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv2d_checker import conv_pkg::*; (
    input  wire logic                      clk_i,
    input  wire logic                      rst_n_i,
    input  wire logic [`CONV_WT_DIM-1:0]   gnt_i,
    input  wire logic [`CONV_WT_DIM-1:0]   req_i,
    input  wire logic                      pix_valid_i,
    input  wire logic                      fm_valid_i,
    input  wire logic                      fifo_full_i,
    input  wire seq_state_t                state_i,
    input  wire logic                      out_valid_i
);

    int         violations = 0;
    logic [3:0] load_cycles_q;

    // cycles spent in SEQ_LOAD, saturates so reset-time load never counts as drain
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            load_cycles_q <= '1;
        end else if (state_i == SEQ_STREAM) begin
            load_cycles_q <= '0;
        end else if (load_cycles_q != '1) begin
            load_cycles_q <= load_cycles_q + 1'b1;
        end
    end

    // one grant at a time, and the winning PE lets its request go on the next edge
    grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (gnt_i != '0) |=> $onehot($past(gnt_i)) && ((req_i & $past(gnt_i)) == '0))
        else begin
            violations++;
            $error("grant not one-hot or granted request still pending");
        end

    pixel_while_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pix_valid_i |-> (req_i == '0))
        else begin
            violations++;
            $error("padded pixel issued while a PE request is still pending");
        end

    fifo_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fm_valid_i |-> !fifo_full_i)
        else begin
            violations++;
            $error("pixel strobe while the input FIFO is full");
        end

    // the last pixel of a frame drains a few cycles after the return to SEQ_LOAD
    output_only_streaming: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i |-> (state_i == SEQ_STREAM) || (load_cycles_q < 4'd8))
        else begin
            violations++;
            $error("output valid in SEQ_LOAD outside the frame drain");
        end

endmodule

`default_nettype wire

// ==== tests/conv2d_tb.sv ====
// Convolution engine testbench
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv2d_tb;

    localparam int DW          = `CONV_DWIDTH;
    localparam int CRD_W       = `CONV_CRD_W;
    localparam int KERNEL_TAPS = `CONV_WT_DIM * `CONV_WT_DIM;
    localparam int TRACE_WORDS = 256;

    logic             clk_i;
    logic             rst_n_i;
    logic [CRD_W-1:0] fm_dim_i;
    logic [DW-1:0]    weight_i;
    logic             weight_valid_i;
    logic [DW-1:0]    fm_data_i;
    logic             fm_valid_i;
    logic [DW-1:0]    out_data_o;
    logic             out_valid_o;
    logic             busy_o;

    logic [DW-1:0]    trace_mem [TRACE_WORDS];
    logic [DW-1:0]    expected_q [$];
    string            name_q [$];
    int               seed;
    int               watch_limit;

    conv2d_top dut_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fm_dim_i       (fm_dim_i),
        .weight_i       (weight_i),
        .weight_valid_i (weight_valid_i),
        .fm_data_i      (fm_data_i),
        .fm_valid_i     (fm_valid_i),
        .out_data_o     (out_data_o),
        .out_valid_o    (out_valid_o),
        .busy_o         (busy_o)
    );

    bind conv2d_top conv2d_checker u_checker (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .gnt_i       (gnt),
        .req_i       (req),
        .pix_valid_i (pix_valid),
        .fm_valid_i  (fm_valid_i),
        .fifo_full_i (u_seq.fifo_full),
        .state_i     (u_seq.state_q),
        .out_valid_i (out_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [DW-1:0] expected,
                               input logic [DW-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic reset_dut();
        rst_n_i = 1'b0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        check_value("reset busy", '0, DW'(busy_o));
        check_value("reset out_valid", '0, DW'(out_valid_o));
    endtask

    // weights row-major on consecutive cycles
    task automatic load_weights(input int base);
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            @(posedge clk_i);
            #1;
            weight_i       = trace_mem[base + k];
            weight_valid_i = 1'b1;
        end
        @(posedge clk_i);
        #1;
        weight_valid_i = 1'b0;
        weight_i       = '0;
    endtask

    // one strobe every 8 cycles plus 0 to 3 random extra
    task automatic stream_pixels(input int base, input int count);
        int extra;
        for (int k = 0; k < count; k++) begin
            @(posedge clk_i);
            #1;
            fm_data_i  = trace_mem[base + k];
            fm_valid_i = 1'b1;
            @(posedge clk_i);
            #1;
            fm_valid_i = 1'b0;
            extra = int'({$random(seed)} % 32'd4);
            repeat (6 + extra) @(posedge clk_i);
        end
    endtask

    task automatic run_frame(input int frame, input int base);
        int dim;
        int pix_base;
        int exp_base;
        dim      = int'(trace_mem[base]);
        pix_base = base + 1 + KERNEL_TAPS;
        exp_base = pix_base + dim * dim;
        for (int y = 0; y < dim; y++) begin
            for (int x = 0; x < dim; x++) begin
                expected_q.push_back(trace_mem[exp_base + y * dim + x]);
                name_q.push_back($sformatf("frame %0d out(%0d,%0d)", frame, y, x));
            end
        end
        @(posedge clk_i);
        #1;
        fm_dim_i = CRD_W'(dim);
        load_weights(base + 1);
        check_value($sformatf("frame %0d busy after weights", frame), 1, DW'(busy_o));
        stream_pixels(pix_base, dim * dim);
        while (expected_q.size() != 0) begin
            @(posedge clk_i);
        end
        #1;
        check_value($sformatf("frame %0d busy between frames", frame), '0, DW'(busy_o));
    endtask

    task automatic run_trace();
        int ptr;
        int dim;
        int frame;
        int limit;
        ptr   = 0;
        limit = 0;
        while (trace_mem[ptr] != '0) begin
            dim   = int'(trace_mem[ptr]);
            limit += (dim + 2) * (dim + 2) * 16 + 200;
            ptr   += 1 + KERNEL_TAPS + 2 * dim * dim;
        end
        watch_limit = limit;
        reset_dut();
        ptr   = 0;
        frame = 1;
        while (trace_mem[ptr] != '0) begin
            dim = int'(trace_mem[ptr]);
            run_frame(frame, ptr);
            ptr   += 1 + KERNEL_TAPS + 2 * dim * dim;
            frame += 1;
        end
        // quiet tail catches any stray output
        repeat (20) @(posedge clk_i);
        if (expected_q.size() != 0) begin
            abort_run("outputs still missing at the end of the trace");
        end else begin
            $display("Test passed");
            $finish;
        end
    endtask

    initial begin : main
        rst_n_i        = 1'b0;
        fm_dim_i       = '0;
        weight_i       = '0;
        weight_valid_i = 1'b0;
        fm_data_i      = '0;
        fm_valid_i     = 1'b0;
        seed           = 25171;
        watch_limit    = 0;
        $readmemh("tests/conv2d_trace.txt", trace_mem);
        if ($isunknown(trace_mem[0]) || trace_mem[0] == '0) begin
            abort_run("trace file holds no frame");
        end else begin
            run_trace();
        end
    end

    always @(negedge clk_i) begin : monitor
        string         name;
        logic [DW-1:0] value;
        if (rst_n_i && out_valid_o) begin
            if (expected_q.size() == 0) begin
                abort_run($sformatf("output %h arrived with no value expected", out_data_o));
            end else begin
                name  = name_q.pop_front();
                value = expected_q.pop_front();
                check_value(name, value, out_data_o);
            end
        end
    end

    always @(negedge clk_i) begin
        if (dut_i.u_checker.violations != 0) begin
            abort_run("bound checker flagged a protocol violation");
        end
    end

    initial begin : watchdog
        wait (watch_limit > 0);
        repeat (watch_limit) @(posedge clk_i);
        abort_run("watchdog expired before all outputs completed");
    end

endmodule

`default_nettype wire

// ==== tests/conv2d_trace.txt ====
// per frame: dimension, nine weights row-major, pixels by row, expected outputs by row
// all words are 32-bit hex, a dimension of 0 ends the trace
// frame 1: all-ones kernel over a 1..16 ramp, border outputs see only in-map terms
00000004
00000001 00000001 00000001
00000001 00000001 00000001
00000001 00000001 00000001
00000001 00000002 00000003 00000004
00000005 00000006 00000007 00000008
00000009 0000000A 0000000B 0000000C
0000000D 0000000E 0000000F 00000010
0000000E 00000018 0000001E 00000016
00000021 00000036 0000003F 0000002D
00000039 0000005A 00000063 00000045
0000002E 00000048 0000004E 00000036
// frame 2: signed kernel over large pixels, sums wrap at 32 bits
00000005
00000002 00000000 FFFFFFFF
00000000 00000003 00000000
FFFFFFFF 00000000 00000001
40000000 40000001 40000002 40000003 40000004
40000005 40000006 40000007 40000008 40000009
4000000A 4000000B 4000000C 4000000D 4000000E
4000000F 40000010 40000011 40000012 40000013
40000014 40000015 40000016 40000017 40000018
00000006 C0000005 C0000008 C000000B 80000004
C0000019 00000012 00000016 0000001A 00000014
C0000028 00000026 0000002A 0000002E 00000028
C0000037 0000003A 0000003E 00000042 0000003C
8000002C 0000004C 00000050 00000054 4000006C
// end of trace
00000000

// ==== tb.f ====
+incdir+common
common/conv_pkg.sv
source/halo_sequencer.sv
source/conv_row_pe.sv
psum/psum_arbiter.sv
psum/psum_buffer.sv
source/conv2d_top.sv
tests/conv2d_checker.sv
tests/conv2d_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the convolution engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module conv2d_tb -f tb.f -o conv2d_sim || exit 1
out=$(./obj_dir/conv2d_sim)
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1
